// ==== acc_butterfly.f ====
+incdir+logic
logic/acc_butterfly_pkg.sv
logic/sample_if.sv
logic/noc_rx_decoder.sv
logic/butterfly_stage.sv
logic/result_fifo.sv
logic/noc_tx_encoder.sv
logic/acc_butterfly_top.sv
sim/tb_acc_butterfly.sv

// ==== logic/acc_butterfly_cfg.svh ====
// Butterfly tile configuration
`ifndef ACC_BUTTERFLY_CFG_SVH
`define ACC_BUTTERFLY_CFG_SVH

// Datapath widths
`define WORD_W              32
`define SAMPLE_W            32
`define RESULT_W            64

// Result buffering
`define FIFO_DEPTH          16              // Power of two
`define FIFO_AFULL          5               // Free entries left at almost-full
`define RESULTS_PER_PKT     4

// Scratchpad addressing
`define SPAD_STEP           12'h040
`define SPAD_W              12

// Packet constants
`define ENABLE_TOGGLE_WORD  32'h8000_0000
`define NOTICE_VALUE        32'd3
`define HOST_DEST           6'b010000
`define NOTICE_DEST         6'b010001
`define OP_MPUT             3'd4
`define OP_NOTICE           3'd3
`define SIZE_CODE           4'd6

`endif

// ==== logic/acc_butterfly_pkg.sv ====
// Butterfly tile types
`include "acc_butterfly_cfg.svh"

package acc_butterfly_pkg;

   //////////////////////////////////////////////////
   // Network words
   //////////////////////////////////////////////////

   // First header word as seen on the NoC
   typedef struct packed {
      logic [2:0] rsvd_top;
      logic       is_data;      // Set for data packets
      logic [2:0] opcode;
      logic       rsvd_op;
      logic [5:0] src_id;
      logic [5:0] rsvd_mid;
      logic [3:0] size_code;
      logic [1:0] rsvd_low;
      logic [5:0] dest;
   } noc_header_t;

   // Header or payload view of one stream word
   typedef union packed {
      logic [`WORD_W-1:0] raw;
      noc_header_t        hdr;
   } noc_word_u;

   //////////////////////////////////////////////////
   // Datapath
   //////////////////////////////////////////////////

   typedef struct packed {
      logic [`SAMPLE_W-1:0] re;   // Upper half
      logic [`SAMPLE_W-1:0] im;
   } cplx_t;

   // Sum goes out first, so it sits in the low word
   typedef struct packed {
      logic [`RESULT_W/2-1:0] hi;
      logic [`RESULT_W/2-1:0] lo;
   } result_t;

   typedef logic [5:0] tile_id_t;

endpackage

// ==== logic/acc_butterfly_top.sv ====
// Butterfly accelerator tile
`timescale 1ns/1ps
`include "acc_butterfly_cfg.svh"

module acc_butterfly_top
   import acc_butterfly_pkg::*;
(
   input  logic               clk_ctrl,
   input  logic               clk_ctrl_rst_low,
   input  logic               in_valid,
   input  logic [`WORD_W-1:0] in_data,
   input  logic               in_last,
   output logic               in_ready,
   output logic               out_valid,
   output logic [`WORD_W-1:0] out_data,
   output logic               out_last,
   input  logic               out_ready,
   input  tile_id_t           tile_id
);

   logic    res_valid;
   result_t res;
   logic    fifo_empty;
   logic    fifo_afull;
   logic    fifo_rd_en;
   result_t fifo_rd_data;
   logic    tx_ready_int;

   sample_if smp_if ();

   //////////////////////////////////////////////////
   // Receive and compute
   //////////////////////////////////////////////////

   noc_rx_decoder rx_dec_i (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .in_valid         (in_valid),
      .in_data          (in_data),
      .in_last          (in_last),
      .in_ready         (in_ready),
      .fifo_afull       (fifo_afull),
      .tx_ready_int     (tx_ready_int),
      .smp              (smp_if.producer)
   );

   butterfly_stage bfly_i (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .smp              (smp_if.consumer),
      .res_valid        (res_valid),
      .res              (res)
   );

   //////////////////////////////////////////////////
   // Buffer and transmit
   //////////////////////////////////////////////////

   result_fifo res_fifo_i (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .wr_en            (res_valid),
      .wr_data          (res),
      .rd_en            (fifo_rd_en),
      .rd_data          (fifo_rd_data),
      .empty            (fifo_empty),
      .afull            (fifo_afull)
   );

   noc_tx_encoder tx_enc_i (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .tile_id          (tile_id),
      .fifo_empty       (fifo_empty),
      .fifo_rd_data     (fifo_rd_data),
      .fifo_rd_en       (fifo_rd_en),
      .out_ready        (out_ready),
      .out_valid        (out_valid),
      .out_data         (out_data),
      .out_last         (out_last),
      .tx_ready_int     (tx_ready_int)
   );

endmodule

// ==== logic/butterfly_stage.sv ====
// Radix-2 butterfly
`timescale 1ns/1ps
`include "acc_butterfly_cfg.svh"

module butterfly_stage
   import acc_butterfly_pkg::*;
(
   input  logic       clk_ctrl,
   input  logic       clk_ctrl_rst_low,
   sample_if.consumer smp,
   output logic       res_valid,
   output result_t    res
);

   logic [1:0]           vld_sr;   // One bit per stage
   logic [`SAMPLE_W-1:0] a_re_q;
   logic [`SAMPLE_W-1:0] b_re_q;

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         vld_sr <= 2'b00;
      end else begin
         vld_sr <= {vld_sr[0], smp.valid};
      end
   end

   // Stage 1 holds the real parts
   always_ff @(posedge clk_ctrl) begin
      if (smp.valid) begin
         a_re_q <= smp.a.re;
         b_re_q <= smp.b.re;
      end
   end

   // Stage 2, wraps modulo 2^32
   always_ff @(posedge clk_ctrl) begin
      if (vld_sr[0]) begin
         res.lo <= a_re_q + b_re_q;
         res.hi <= a_re_q - b_re_q;
      end
   end

   assign res_valid = vld_sr[1];

endmodule

// ==== logic/noc_rx_decoder.sv ====
// NoC receive decoder
`timescale 1ns/1ps
`include "acc_butterfly_cfg.svh"

module noc_rx_decoder
   import acc_butterfly_pkg::*;
(
   input  logic       clk_ctrl,
   input  logic       clk_ctrl_rst_low,
   input  logic       in_valid,
   input  noc_word_u  in_data,
   input  logic       in_last,
   output logic       in_ready,
   input  logic       fifo_afull,
   input  logic       tx_ready_int,
   sample_if.producer smp
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HDR2,
      ST_A_RE,
      ST_A_IM,
      ST_B_RE,
      ST_B_IM,
      ST_CTRL,
      ST_DROP
   } rx_state_e;

   rx_state_e state;
   logic      enable_q;
   logic      valid_q;
   cplx_t     a_q;
   cplx_t     b_q;
   logic      take;

   // Stall on result back-pressure or a blocked output
   assign in_ready = ~fifo_afull & tx_ready_int;
   assign take     = in_valid & in_ready;

   //////////////////////////////////////////////////
   // Packet walk
   //////////////////////////////////////////////////

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         state    <= ST_IDLE;
         enable_q <= 1'b0;
         valid_q  <= 1'b0;
      end else begin
         valid_q <= 1'b0;
         if (take) begin
            case (state)
               ST_IDLE: begin
                  if (!in_data.hdr.is_data) begin
                     state <= ST_CTRL;
                  end else if (enable_q) begin
                     state <= ST_HDR2;
                  end else if (!in_last) begin
                     state <= ST_DROP;   // Tile off, swallow the packet
                  end
               end
               ST_HDR2: state <= ST_A_RE;
               ST_A_RE: state <= ST_A_IM;
               ST_A_IM: state <= ST_B_RE;
               ST_B_RE: state <= ST_B_IM;
               ST_B_IM: begin
                  valid_q <= 1'b1;
                  state   <= in_last ? ST_IDLE : ST_A_RE;
               end
               ST_CTRL: begin
                  // Anything but the toggle word is ignored
                  if (in_data.raw == `ENABLE_TOGGLE_WORD) begin
                     enable_q <= ~enable_q;
                  end
                  state <= ST_IDLE;
               end
               ST_DROP: begin
                  if (in_last) begin
                     state <= ST_IDLE;
                  end
               end
               default: state <= ST_IDLE;
            endcase
         end
      end
   end

   // Sample capture
   always_ff @(posedge clk_ctrl) begin
      if (take) begin
         case (state)
            ST_A_RE: a_q.re <= in_data.raw;
            ST_A_IM: a_q.im <= in_data.raw;
            ST_B_RE: b_q.re <= in_data.raw;
            ST_B_IM: b_q.im <= in_data.raw;
            default: ;
         endcase
      end
   end

   assign smp.valid  = valid_q;
   assign smp.a      = a_q;
   assign smp.b      = b_q;
   assign smp.enable = enable_q;

   // A pair reaches the butterfly only from an enabled tile
   a_no_sample_when_off: assert property (
      @(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      $rose(smp.valid) |-> smp.enable
   );

endmodule

// ==== logic/noc_tx_encoder.sv ====
// NoC transmit encoder
`timescale 1ns/1ps
`include "acc_butterfly_cfg.svh"

module noc_tx_encoder
   import acc_butterfly_pkg::*;
(
   input  logic               clk_ctrl,
   input  logic               clk_ctrl_rst_low,
   input  tile_id_t           tile_id,
   input  logic               fifo_empty,
   input  result_t            fifo_rd_data,
   output logic               fifo_rd_en,
   input  logic               out_ready,
   output logic               out_valid,
   output logic [`WORD_W-1:0] out_data,
   output logic               out_last,
   output logic               tx_ready_int
);

   localparam int         CNT_W      = $clog2(`RESULTS_PER_PKT + 1);
   localparam int         ADDR_PAD   = `WORD_W - 6 - `SPAD_W;
   localparam logic [5:0] NOTICE_SRC = 6'b001000;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HDR,
      ST_ADDR,
      ST_LO,
      ST_HI,
      ST_HOLD,
      ST_NHDR,
      ST_NVAL
   } tx_state_e;

   tx_state_e          state;
   tx_state_e          state_nxt;
   logic [CNT_W-1:0]   res_cnt;      // Pairs left in this packet
   logic [CNT_W-1:0]   res_cnt_nxt;
   logic [`SPAD_W-1:0] spad_off;
   logic [`SPAD_W-1:0] spad_off_nxt;
   noc_word_u          pkt_hdr;
   noc_word_u          ntc_hdr;

   assign tx_ready_int = out_ready;   // Input side stalls with the output

   //////////////////////////////////////////////////
   // Header words
   //////////////////////////////////////////////////

   always_comb begin
      pkt_hdr               = '0;
      pkt_hdr.hdr.is_data   = 1'b1;
      pkt_hdr.hdr.opcode    = `OP_MPUT;
      pkt_hdr.hdr.src_id    = tile_id;
      pkt_hdr.hdr.size_code = `SIZE_CODE;
      pkt_hdr.hdr.dest      = `HOST_DEST;

      ntc_hdr               = '0;   // Control packet, no size
      ntc_hdr.hdr.opcode    = `OP_NOTICE;
      ntc_hdr.hdr.src_id    = NOTICE_SRC;
      ntc_hdr.hdr.dest      = `NOTICE_DEST;
   end

   //////////////////////////////////////////////////
   // Output FSM
   //////////////////////////////////////////////////

   always_comb begin
      state_nxt    = state;
      res_cnt_nxt  = res_cnt;
      spad_off_nxt = spad_off;
      fifo_rd_en   = 1'b0;
      out_valid    = 1'b0;
      out_data     = '0;
      out_last     = 1'b0;

      case (state)
         ST_IDLE: begin
            if (out_ready && !fifo_empty) state_nxt = ST_HDR;
         end
         ST_HDR: begin
            if (out_ready) begin
               out_valid   = 1'b1;
               out_data    = pkt_hdr.raw;
               res_cnt_nxt = CNT_W'(`RESULTS_PER_PKT);
               state_nxt   = ST_ADDR;
            end
         end
         ST_ADDR: begin
            if (out_ready) begin
               out_valid  = 1'b1;
               out_data   = {{ADDR_PAD{1'b0}}, `HOST_DEST, spad_off};
               fifo_rd_en = 1'b1;   // First pair lands for ST_LO
               state_nxt  = ST_LO;
            end
         end
         ST_LO: begin
            if (out_ready) begin
               out_valid = 1'b1;
               out_data  = fifo_rd_data.lo;
               state_nxt = ST_HI;
            end
         end
         ST_HI: begin
            if (out_ready) begin
               out_valid   = 1'b1;
               out_data    = fifo_rd_data.hi;
               res_cnt_nxt = res_cnt - 1'b1;
               if (res_cnt == CNT_W'(1)) begin
                  out_last  = 1'b1;
                  state_nxt = ST_NHDR;
               end else if (!fifo_empty) begin
                  fifo_rd_en = 1'b1;
                  state_nxt  = ST_LO;
               end else begin
                  state_nxt = ST_HOLD;
               end
            end
         end
         // Wait for the butterfly to catch up
         ST_HOLD: begin
            if (!fifo_empty) begin
               fifo_rd_en = 1'b1;
               state_nxt  = ST_LO;
            end
         end
         ST_NHDR: begin
            if (out_ready) begin
               out_valid = 1'b1;
               out_data  = ntc_hdr.raw;
               state_nxt = ST_NVAL;
            end
         end
         ST_NVAL: begin
            if (out_ready) begin
               out_valid    = 1'b1;
               out_data     = `NOTICE_VALUE;
               out_last     = 1'b1;
               spad_off_nxt = spad_off + `SPAD_STEP;   // Next scratchpad slot
               state_nxt    = ST_IDLE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         state    <= ST_IDLE;
         res_cnt  <= '0;
         spad_off <= '0;
      end else begin
         state    <= state_nxt;
         res_cnt  <= res_cnt_nxt;
         spad_off <= spad_off_nxt;
      end
   end

   // Pair count stays loaded through the payload
   a_res_cnt_live: assert property (
      @(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      (state inside {ST_LO, ST_HI, ST_HOLD}) |-> (res_cnt != '0)
   );

endmodule

// ==== logic/result_fifo.sv ====
// Result FIFO
`timescale 1ns/1ps
`include "acc_butterfly_cfg.svh"

module result_fifo
   import acc_butterfly_pkg::*;
(
   input  logic    clk_ctrl,
   input  logic    clk_ctrl_rst_low,
   input  logic    wr_en,
   input  result_t wr_data,
   input  logic    rd_en,
   output result_t rd_data,
   output logic    empty,
   output logic    afull
);

   localparam int PTR_W = $clog2(`FIFO_DEPTH);
   localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

   result_t          mem [`FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;

   assign empty = (count == '0);
   assign full  = (count == CNT_W'(`FIFO_DEPTH));
   assign afull = (count >= CNT_W'(`FIFO_DEPTH - `FIFO_AFULL));   // Headroom for in-flight pairs

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage and registered read port
   always_ff @(posedge clk_ctrl) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
      if (rd_en) begin
         rd_data <= mem[rd_ptr];
      end
   end

   a_no_overflow: assert property (
      @(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low) wr_en |-> !full
   );

   a_no_underflow: assert property (
      @(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low) rd_en |-> !empty
   );

endmodule

// ==== logic/sample_if.sv ====
// Sample pair link
`timescale 1ns/1ps

interface sample_if
   import acc_butterfly_pkg::*;
();

   logic  valid;    // One-cycle pulse per pair
   cplx_t a;
   cplx_t b;
   logic  enable;   // Decoder enable level

   modport producer (
      output valid, a, b, enable
   );

   modport consumer (
      input valid, a, b
   );

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the butterfly tile testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_acc_butterfly -f acc_butterfly.f

sim_out=$(./obj_dir/Vtb_acc_butterfly)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1

// ==== sim/tb_acc_butterfly.sv ====
// Butterfly tile testbench
`timescale 1ns/1ps
`include "acc_butterfly_cfg.svh"

module tb_acc_butterfly;

   // Tests run for about 500 cycles, so this leaves a wide margin
   localparam int MAX_CYCLES = 4000;
   localparam logic [31:0] DATA_HDR0 = 32'h1800_0610;   // Bit 28 set
   localparam logic [31:0] DATA_HDR1 = 32'h0000_0000;
   localparam logic [31:0] CTRL_HDR  = 32'h0600_0011;   // Bit 28 clear

   logic        clk_ctrl;
   logic        clk_ctrl_rst_low;
   logic        in_valid;
   logic [31:0] in_data;
   logic        in_last;
   logic        in_ready;
   logic        out_valid;
   logic [31:0] out_data;
   logic        out_last;
   logic        out_ready;
   logic [5:0]  tile_id;

   logic [31:0] lcg_state = 32'd54;
   logic        ready_random;
   int          err_count  = 0;
   int          pass_count = 0;
   int          cycle_count = 0;
   logic [31:0] out_words [$];
   logic        out_lasts [$];
   logic [31:0] pair_are [4];
   logic [31:0] pair_aim [4];
   logic [31:0] pair_bre [4];
   logic [31:0] pair_bim [4];

   acc_butterfly_top dut_i (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .in_valid         (in_valid),
      .in_data          (in_data),
      .in_last          (in_last),
      .in_ready         (in_ready),
      .out_valid        (out_valid),
      .out_data         (out_data),
      .out_last         (out_last),
      .out_ready        (out_ready),
      .tile_id          (tile_id)
   );

   initial begin
      clk_ctrl = 1'b0;
      forever #4 clk_ctrl = ~clk_ctrl;
   end

   //////////////////////////////////////////////////
   // Helpers and reference model
   //////////////////////////////////////////////////

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic logic [31:0] pkt_header_word(input logic [5:0] tid);
      return 32'h1000_0000 | (32'(`OP_MPUT) << 25) | (32'(tid) << 18)
           | (32'(`SIZE_CODE) << 8) | 32'(`HOST_DEST);
   endfunction

   function automatic logic [31:0] notice_header_word();
      return (32'(`OP_NOTICE) << 25) | (32'(6'b001000) << 18) | 32'(`NOTICE_DEST);
   endfunction

   task automatic report_error(input string msg);
      err_count++;
      $display("error at %0t: %s", $time, msg);
   endtask

   task automatic send_word(input logic [31:0] w, input logic last);
      logic took;
      in_valid <= 1'b1;
      in_data  <= w;
      in_last  <= last;
      took = 1'b0;
      while (!took) begin
         @(negedge clk_ctrl);
         took = in_ready;   // Stable until the next edge
         @(posedge clk_ctrl);
      end
   endtask

   task automatic send_control(input logic [31:0] w);
      send_word(CTRL_HDR, 1'b0);
      send_word(w, 1'b1);
      in_valid <= 1'b0;
      in_last  <= 1'b0;
   endtask

   task automatic send_data_packet();
      send_word(DATA_HDR0, 1'b0);
      send_word(DATA_HDR1, 1'b0);
      for (int i = 0; i < 4; i++) begin
         send_word(pair_are[i], 1'b0);
         send_word(pair_aim[i], 1'b0);
         send_word(pair_bre[i], 1'b0);
         send_word(pair_bim[i], i == 3);
      end
      in_valid <= 1'b0;
      in_last  <= 1'b0;
   endtask

   task automatic fill_random_pairs();
      for (int i = 0; i < 4; i++) begin
         pair_are[i] = lcg_next();
         pair_aim[i] = lcg_next();
         pair_bre[i] = lcg_next();
         pair_bim[i] = lcg_next();
      end
   endtask

   task automatic wait_words(input int test_no, input int n, input int limit);
      int waited;
      waited = 0;
      while (out_words.size() < n && waited < limit) begin
         @(posedge clk_ctrl);
         waited++;
      end
      if (out_words.size() < n) begin
         err_count++;
         $display("test %0d: only %0d of %0d output words arrived within %0d cycles",
                  test_no, out_words.size(), n, limit);
      end
   endtask

   // Header, address, lo/hi per pair, then the notice
   task automatic check_packet(input int test_no, input logic [11:0] offset);
      logic [31:0] exp_w [12];
      logic        exp_l [12];
      exp_w[0] = pkt_header_word(tile_id);
      exp_w[1] = (32'(`HOST_DEST) << 12) | 32'(offset);
      for (int i = 0; i < 4; i++) begin
         exp_w[2 + 2*i] = pair_are[i] + pair_bre[i];
         exp_w[3 + 2*i] = pair_are[i] - pair_bre[i];
      end
      exp_w[10] = notice_header_word();
      exp_w[11] = `NOTICE_VALUE;
      for (int i = 0; i < 12; i++) exp_l[i] = (i == 9) || (i == 11);
      if (out_words.size() != 12) begin
         report_error($sformatf("test %0d: got %0d output words, expected 12",
                                test_no, out_words.size()));
      end else begin
         for (int i = 0; i < 12; i++) begin
            if (out_words[i] !== exp_w[i] || out_lasts[i] !== exp_l[i]) begin
               report_error($sformatf("test %0d word %0d: got %h/%b, expected %h/%b",
                            test_no, i, out_words[i], out_lasts[i], exp_w[i], exp_l[i]));
            end else begin
               pass_count++;
            end
         end
      end
      out_words.delete();
      out_lasts.delete();
   endtask

   task automatic expect_no_output(input int test_no);
      repeat (100) @(posedge clk_ctrl);
      if (out_words.size() != 0) begin
         report_error($sformatf("test %0d: %0d words sent by a disabled tile",
                                test_no, out_words.size()));
      end else begin
         pass_count++;
      end
      out_words.delete();
      out_lasts.delete();
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic test_idle_after_reset();
      repeat (20) begin
         @(negedge clk_ctrl);
         if (out_valid !== 1'b0) report_error("test 1: out_valid high after reset");
         else if (in_ready !== 1'b1) report_error("test 1: in_ready low after reset");
         else pass_count++;
      end
      @(posedge clk_ctrl);
   endtask

   task automatic test_disabled_drop();
      fill_random_pairs();
      send_data_packet();
      expect_no_output(2);
   endtask

   task automatic test_enabled_packet();
      send_control(`ENABLE_TOGGLE_WORD);
      fill_random_pairs();
      send_data_packet();
      wait_words(3, 12, 200);
      check_packet(3, 12'h000);
   endtask

   task automatic test_wrap_packet();
      pair_are = '{32'hFFFF_FFF0, 32'h0000_0001, 32'h8000_0000, 32'hFFFF_FFFF};
      pair_bre = '{32'h0000_0020, 32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF};
      pair_aim = '{32'h1, 32'h2, 32'h3, 32'h4};
      pair_bim = '{32'h5, 32'h6, 32'h7, 32'h8};
      send_data_packet();
      wait_words(4, 12, 200);
      check_packet(4, 12'h040);
   endtask

   task automatic test_random_ready();
      fill_random_pairs();   // Before the ready driver starts drawing numbers
      ready_random <= 1'b1;
      send_data_packet();
      wait_words(5, 12, 600);
      ready_random <= 1'b0;
      check_packet(5, 12'h080);
   endtask

   task automatic test_disable_again();
      send_control(`ENABLE_TOGGLE_WORD);
      fill_random_pairs();
      send_data_packet();
      expect_no_output(6);
   endtask

   //////////////////////////////////////////////////
   // Processes
   //////////////////////////////////////////////////

   // Output monitor, samples mid-cycle
   always @(negedge clk_ctrl) begin
      if (clk_ctrl_rst_low && out_valid) begin
         out_words.push_back(out_data);
         out_lasts.push_back(out_last);
         if (!out_ready) report_error("out_valid high while out_ready low");
      end
   end

   initial begin : ready_drive
      logic [31:0] rnd;
      out_ready <= 1'b1;
      forever begin
         @(posedge clk_ctrl);
         if (ready_random) begin
            rnd = lcg_next();
            out_ready <= rnd[16];
         end else begin
            out_ready <= 1'b1;
         end
      end
   end

   initial begin : watchdog
      while (cycle_count < MAX_CYCLES) begin
         @(posedge clk_ctrl);
         cycle_count++;
      end
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("summary: %0d passed, %0d errors", pass_count, err_count);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      clk_ctrl_rst_low <= 1'b0;
      in_valid         <= 1'b0;
      in_data          <= '0;
      in_last          <= 1'b0;
      tile_id          <= 6'h2A;
      ready_random     <= 1'b0;
      repeat (5) @(posedge clk_ctrl);
      clk_ctrl_rst_low <= 1'b1;
      @(posedge clk_ctrl);

      test_idle_after_reset();
      test_disabled_drop();
      test_enabled_packet();
      test_wrap_packet();
      test_random_ready();
      test_disable_again();

      $display("summary: %0d passed, %0d errors", pass_count, err_count);
      if (err_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
